// ==== Makefile ====
# Verilator build, run, lint and clean for the free-list tracker

TOP := tb_freelist_tracker

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f freelist_tracker.f --top-module $(TOP)

# The run fails unless the pass line appears in the output
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
	  -f freelist_tracker.f --top-module freelist_tracker

clean:
	rm -rf obj_dir

// ==== alloc_staging_buffer.sv ====
/*
  Allocation staging buffer
  Registered multi-transfer buffer of up to NUM_ALLOC_PER_CYCLE entry IDs.
  Pops take IDs from the front, pushes append behind the survivors.
*/

module alloc_staging_buffer #(
  parameter int NUM_ALLOC_PER_CYCLE = freelist_pkg::default_alloc_per_cycle,
  parameter int ID_WIDTH = freelist_pkg::id_width(freelist_pkg::default_num_entries),
  localparam int CW = freelist_pkg::count_width(NUM_ALLOC_PER_CYCLE)
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [CW-1:0]                                push_sendable,
  input  logic [NUM_ALLOC_PER_CYCLE-1:0][ID_WIDTH-1:0] push_data,
  output logic [CW-1:0]                                push_receivable,
  output logic [CW-1:0]                                pop_sendable,
  output logic [NUM_ALLOC_PER_CYCLE-1:0][ID_WIDTH-1:0] pop_data,
  input  logic [CW-1:0]                                pop_receivable
);

  // Number of valid IDs held in slots 0 to count-1
  logic [CW-1:0] count;
  logic [CW-1:0] count_next;
  logic [NUM_ALLOC_PER_CYCLE-1:0][ID_WIDTH-1:0] data;
  logic [NUM_ALLOC_PER_CYCLE-1:0][ID_WIDTH-1:0] data_next;

  logic [CW-1:0] pop_count;
  logic [CW-1:0] kept_count;
  logic [CW-1:0] space;

  // Transfer size on the pop side is the smaller of the two counts
  assign pop_count = (pop_receivable < count) ? pop_receivable : count;

  // IDs that survive this cycle's pops
  assign kept_count = count - pop_count;

  // Space includes the slots freed by pops in the same cycle, so a full
  // buffer that is being drained can refill without a bubble
  assign space = CW'(NUM_ALLOC_PER_CYCLE) - kept_count;

  assign push_receivable = (push_sendable < space) ? push_sendable : space;

  assign count_next = kept_count + push_receivable;

  // Shift survivors down to slot 0 and append accepted pushes behind them
  always_comb begin
    int src;
    int dst;
    data_next = data;
    for (int i = 0; i < NUM_ALLOC_PER_CYCLE; i++) begin
      src = i + int'(pop_count);
      dst = i - int'(kept_count);
      if (i < int'(kept_count)) begin
        data_next[i] = data[src];
      end else if (dst < int'(push_receivable)) begin
        data_next[i] = push_data[dst];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // Only the slots below count hold IDs on offer
  always_ff @(posedge clk) begin
    data <= data_next;
  end

  assign pop_sendable = count;
  assign pop_data = data;

endmodule

// ==== dealloc_counter.sv ====
/*
  Deallocation counter
  Counts valid deallocations per cycle and delays the count by
  DEALLOC_COUNT_DELAY register stages for credit return.
*/

module dealloc_counter #(
  parameter int NUM_DEALLOC_PORTS = freelist_pkg::default_dealloc_ports,
  parameter int DEALLOC_COUNT_DELAY = freelist_pkg::default_dealloc_count_delay,
  localparam int CW = freelist_pkg::count_width(NUM_DEALLOC_PORTS)
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [NUM_DEALLOC_PORTS-1:0] dealloc_valid,
  output logic [CW-1:0]                dealloc_count
);

  logic [CW-1:0] count_now;

  // Population count of the valid bits
  always_comb begin
    count_now = '0;
    for (int i = 0; i < NUM_DEALLOC_PORTS; i++) begin
      count_now += CW'(dealloc_valid[i]);
    end
  end

  if (DEALLOC_COUNT_DELAY == 0) begin : gen_no_delay
    assign dealloc_count = count_now;
  end else begin : gen_delay
    // Stage 0 holds the newest count
    logic [DEALLOC_COUNT_DELAY-1:0][CW-1:0] stages;

    always_ff @(posedge clk) begin
      if (rst) begin
        stages <= '0;
      end else begin
        stages[0] <= count_now;
        for (int i = 1; i < DEALLOC_COUNT_DELAY; i++) begin
          stages[i] <= stages[i-1];
        end
      end
    end

    assign dealloc_count = stages[DEALLOC_COUNT_DELAY-1];
  end

endmodule

// ==== free_vector.sv ====
/*
  Free vector
  One bit per entry that is free and not yet staged for allocation.
  Deallocations set bits and entries pushed into staging clear them.
*/

module free_vector #(
  parameter int NUM_ENTRIES = freelist_pkg::default_num_entries,
  parameter int NUM_ALLOC_PER_CYCLE = freelist_pkg::default_alloc_per_cycle,
  parameter int NUM_DEALLOC_PORTS = freelist_pkg::default_dealloc_ports,
  localparam int ID_W = freelist_pkg::id_width(NUM_ENTRIES),
  localparam int CW = freelist_pkg::count_width(NUM_ALLOC_PER_CYCLE)
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [NUM_DEALLOC_PORTS-1:0]                     dealloc_valid,
  input  logic [NUM_DEALLOC_PORTS-1:0][ID_W-1:0]           dealloc_entry_id,
  input  logic [NUM_ALLOC_PER_CYCLE-1:0][NUM_ENTRIES-1:0]  push_onehot,
  input  logic [CW-1:0]                                    push_receivable,
  output logic [NUM_ENTRIES-1:0]                           free_entries
);

  logic [NUM_ENTRIES-1:0] set_mask;
  logic [NUM_ENTRIES-1:0] clear_mask;
  logic [NUM_ENTRIES-1:0] free_next;

  // Decode every returned ID to one-hot and merge the ports
  always_comb begin
    set_mask = '0;
    for (int i = 0; i < NUM_DEALLOC_PORTS; i++) begin
      // IDs beyond the pool size are ignored rather than aliased
      if (dealloc_valid[i] && (int'(dealloc_entry_id[i]) < NUM_ENTRIES)) begin
        set_mask[dealloc_entry_id[i]] = 1'b1;
      end
    end
  end

  // Only the slots the staging buffer accepted leave the free vector
  always_comb begin
    clear_mask = '0;
    for (int i = 0; i < NUM_ALLOC_PER_CYCLE; i++) begin
      if (int'(push_receivable) > i) begin
        clear_mask |= push_onehot[i];
      end
    end
  end

  // Clear bits always come from entries that are already free, while set
  // bits come from entries held by the user, so the two never overlap for
  // legal traffic and clearing only affects bits that were free
  assign free_next = (free_entries | set_mask) & ~clear_mask;

  // Every entry starts free out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      free_entries <= '1;
    end else begin
      free_entries <= free_next;
    end
  end

endmodule

// ==== freelist_pkg.sv ====
/*
  Free-list tracker package
  Default pool sizes and the width helpers that every block of the
  tracker uses to size entry IDs and counts.
*/

package freelist_pkg;

  // Number of entries in the pool
  localparam int default_num_entries = 8;

  // Number of IDs that can be offered on the allocation port per cycle
  localparam int default_alloc_per_cycle = 2;

  // Number of parallel deallocation ports
  localparam int default_dealloc_ports = 2;

  // Delay of dealloc_count that equals the cut-through latency by default
  localparam int default_dealloc_count_delay = 2;

  // Width of an entry ID for a pool of n entries and never below one bit
  function automatic int id_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Width needed for a count from 0 to n inclusive
  function automatic int count_width(input int n);
    return (n > 0) ? $clog2(n + 1) : 1;
  endfunction

endpackage

// ==== freelist_tracker.f ====
freelist_pkg.sv
free_vector.sv
multi_priority_encoder.sv
alloc_staging_buffer.sv
dealloc_counter.sv
freelist_tracker.sv
tb_freelist_tracker.sv

// ==== freelist_tracker.sv ====
/*
  Free-list tracker
  Hands out up to NUM_ALLOC_PER_CYCLE free entry IDs per cycle through a
  registered multi-transfer port and takes IDs back on parallel ports.
  Cut-through latency from deallocation to allocation is two cycles.
*/

module freelist_tracker #(
  parameter int NUM_ENTRIES = freelist_pkg::default_num_entries,
  parameter int NUM_ALLOC_PER_CYCLE = freelist_pkg::default_alloc_per_cycle,
  parameter int NUM_DEALLOC_PORTS = freelist_pkg::default_dealloc_ports,
  // Legal range is 0 up to the cut-through latency of 2
  parameter int DEALLOC_COUNT_DELAY = freelist_pkg::default_dealloc_count_delay,
  localparam int ID_W = freelist_pkg::id_width(NUM_ENTRIES),
  localparam int ACW = freelist_pkg::count_width(NUM_ALLOC_PER_CYCLE),
  localparam int DCW = freelist_pkg::count_width(NUM_DEALLOC_PORTS)
) (
  input  logic                                    clk,
  input  logic                                    rst,

  // Allocation port with slots 0 to alloc_sendable-1 valid
  input  logic [ACW-1:0]                          alloc_receivable,
  output logic [ACW-1:0]                          alloc_sendable,
  output logic [NUM_ALLOC_PER_CYCLE-1:0][ID_W-1:0] alloc_entry_id,

  // Deallocation ports have no back-pressure
  input  logic [NUM_DEALLOC_PORTS-1:0]            dealloc_valid,
  input  logic [NUM_DEALLOC_PORTS-1:0][ID_W-1:0]  dealloc_entry_id,
  output logic [DCW-1:0]                          dealloc_count
);

  logic [NUM_ENTRIES-1:0]                          free_entries;
  logic [NUM_ALLOC_PER_CYCLE-1:0][NUM_ENTRIES-1:0] push_onehot;
  logic [NUM_ALLOC_PER_CYCLE-1:0][ID_W-1:0]        push_data;
  logic [ACW-1:0]                                  push_sendable;
  logic [ACW-1:0]                                  push_receivable;

  // Free entries that have not yet been staged
  free_vector #(
    .NUM_ENTRIES         (NUM_ENTRIES),
    .NUM_ALLOC_PER_CYCLE (NUM_ALLOC_PER_CYCLE),
    .NUM_DEALLOC_PORTS   (NUM_DEALLOC_PORTS)
  ) u_free_vector (
    .clk              (clk),
    .rst              (rst),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .push_onehot      (push_onehot),
    .push_receivable  (push_receivable),
    .free_entries     (free_entries)
  );

  // Lowest-index-first selection feeds the push side of the buffer
  multi_priority_encoder #(
    .NUM_ENTRIES         (NUM_ENTRIES),
    .NUM_ALLOC_PER_CYCLE (NUM_ALLOC_PER_CYCLE)
  ) u_multi_priority_encoder (
    .free_entries  (free_entries),
    .slot_onehot   (push_onehot),
    .slot_id       (push_data),
    .slot_sendable (push_sendable)
  );

  // Registered allocation outputs
  alloc_staging_buffer #(
    .NUM_ALLOC_PER_CYCLE (NUM_ALLOC_PER_CYCLE),
    .ID_WIDTH            (ID_W)
  ) u_alloc_staging_buffer (
    .clk             (clk),
    .rst             (rst),
    .push_sendable   (push_sendable),
    .push_data       (push_data),
    .push_receivable (push_receivable),
    .pop_sendable    (alloc_sendable),
    .pop_data        (alloc_entry_id),
    .pop_receivable  (alloc_receivable)
  );

  // Delayed count of returned IDs for credit returns
  dealloc_counter #(
    .NUM_DEALLOC_PORTS   (NUM_DEALLOC_PORTS),
    .DEALLOC_COUNT_DELAY (DEALLOC_COUNT_DELAY)
  ) u_dealloc_counter (
    .clk           (clk),
    .rst           (rst),
    .dealloc_valid (dealloc_valid),
    .dealloc_count (dealloc_count)
  );

endmodule

// ==== multi_priority_encoder.sv ====
/*
  Multi-result priority encoder
  Picks up to NUM_ALLOC_PER_CYCLE free entries, lowest index first, and
  returns them as one-hot and binary IDs packed from slot 0 upward.
*/

module multi_priority_encoder #(
  parameter int NUM_ENTRIES = freelist_pkg::default_num_entries,
  parameter int NUM_ALLOC_PER_CYCLE = freelist_pkg::default_alloc_per_cycle,
  localparam int ID_W = freelist_pkg::id_width(NUM_ENTRIES),
  localparam int CW = freelist_pkg::count_width(NUM_ALLOC_PER_CYCLE)
) (
  input  logic [NUM_ENTRIES-1:0]                           free_entries,
  output logic [NUM_ALLOC_PER_CYCLE-1:0][NUM_ENTRIES-1:0]  slot_onehot,
  output logic [NUM_ALLOC_PER_CYCLE-1:0][ID_W-1:0]         slot_id,
  output logic [CW-1:0]                                    slot_sendable
);

  logic [NUM_ALLOC_PER_CYCLE-1:0] slot_valid;

  // Each slot takes the lowest remaining set bit and masks it out for the
  // slots above it, so results come out in ascending index order
  always_comb begin
    logic [NUM_ENTRIES-1:0] remaining;
    remaining = free_entries;
    for (int s = 0; s < NUM_ALLOC_PER_CYCLE; s++) begin
      // Two's complement trick isolates the lowest set bit
      slot_onehot[s] = remaining & (~remaining + NUM_ENTRIES'(1));
      remaining = remaining & ~slot_onehot[s];
    end
  end

  // One-hot to binary per slot
  always_comb begin
    for (int s = 0; s < NUM_ALLOC_PER_CYCLE; s++) begin
      slot_id[s] = '0;
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        if (slot_onehot[s][e]) begin
          slot_id[s] |= ID_W'(e);
        end
      end
      slot_valid[s] = |slot_onehot[s];
    end
  end

  // Valid slots are contiguous from slot 0, so their count is the
  // number of IDs that can be pushed into staging
  always_comb begin
    slot_sendable = '0;
    for (int s = 0; s < NUM_ALLOC_PER_CYCLE; s++) begin
      slot_sendable += CW'(slot_valid[s]);
    end
  end

endmodule

// ==== tb_freelist_tracker.sv ====
/*
  Free-list tracker testbench
  Directed start-up, exhaustion, latency and count checks, then random
  allocation and return traffic against a model of the IDs held here.
*/

module tb_freelist_tracker;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ENTRIES = freelist_pkg::default_num_entries;
  localparam int NUM_ALLOC = freelist_pkg::default_alloc_per_cycle;
  localparam int NUM_PORTS = freelist_pkg::default_dealloc_ports;
  localparam int DELAY = freelist_pkg::default_dealloc_count_delay;
  localparam int ID_W = freelist_pkg::id_width(NUM_ENTRIES);
  localparam int ACW = freelist_pkg::count_width(NUM_ALLOC);
  localparam int DCW = freelist_pkg::count_width(NUM_PORTS);
  localparam int TIMEOUT = 100;

  logic clk;
  logic rst;
  logic [ACW-1:0] alloc_receivable;
  logic [ACW-1:0] alloc_sendable;
  logic [NUM_ALLOC-1:0][ID_W-1:0] alloc_entry_id;
  logic [NUM_PORTS-1:0] dealloc_valid;
  logic [NUM_PORTS-1:0][ID_W-1:0] dealloc_entry_id;
  logic [DCW-1:0] dealloc_count;

  // Reference model of the IDs held by the testbench and of recent return counts
  logic [NUM_ENTRIES-1:0] owned;
  int count_hist [2] = '{0, 0};
  int accepted [$];
  int seed;
  int error_count;

  freelist_tracker #(
    .NUM_ENTRIES         (NUM_ENTRIES),
    .NUM_ALLOC_PER_CYCLE (NUM_ALLOC),
    .NUM_DEALLOC_PORTS   (NUM_PORTS),
    .DEALLOC_COUNT_DELAY (DELAY)
  ) u_freelist_tracker (
    .clk              (clk),
    .rst              (rst),
    .alloc_receivable (alloc_receivable),
    .alloc_sendable   (alloc_sendable),
    .alloc_entry_id   (alloc_entry_id),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .dealloc_count    (dealloc_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_timeout(input string msg);
    error_count++;
    $display("Timed out: %s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped after a timeout");
  endtask

  function automatic int count_valid(input logic [NUM_PORTS-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      n += int'(v[i]);
    end
    return n;
  endfunction

  // The count seen now was returned DELAY cycles ago and history slot 0 is one cycle back
  function automatic int expected_dealloc_count(input int current);
    int back;
    back = DELAY - 1;
    if (DELAY == 0) begin
      return current;
    end
    return count_hist[back];
  endfunction

  // An offered ID must lie in the pool and must not be held already
  function automatic bit legal_alloc(input int id);
    return (id >= 0) && (id < NUM_ENTRIES) && !owned[id];
  endfunction

  // Samples before the edge updates anything, so inputs and outputs match
  always @(posedge clk) begin : check_outputs
    int now_count;
    int taken;
    int id;
    now_count = count_valid(dealloc_valid);
    if (!rst) begin
      assert (int'(dealloc_count) == expected_dealloc_count(now_count)) else
        report_mismatch($sformatf("dealloc_count is %0d, expected %0d",
                                  dealloc_count, expected_dealloc_count(now_count)));
      assert (int'(alloc_sendable) <= NUM_ALLOC) else
        report_mismatch($sformatf("alloc_sendable is %0d", alloc_sendable));
      taken = (alloc_receivable < alloc_sendable) ? int'(alloc_receivable)
                                                  : int'(alloc_sendable);
      for (int s = 0; s < int'(alloc_sendable) && s < NUM_ALLOC; s++) begin
        id = int'(alloc_entry_id[s]);
        assert (legal_alloc(id)) else
          report_mismatch($sformatf("slot %0d offers ID %0d, which is held", s, id));
        for (int o = 0; o < s; o++) begin
          assert (int'(alloc_entry_id[o]) != id) else
            report_mismatch($sformatf("slots %0d and %0d both offer ID %0d", o, s, id));
        end
        // Lowest slots transfer first
        if (s < taken) begin
          owned[id] = 1'b1;
          accepted.push_back(id);
        end
      end
    end
    count_hist[1] = count_hist[0];
    count_hist[0] = now_count;
  end

  // Called at a falling edge, drives one cycle and returns at the next falling edge
  task automatic drive_cycle(input int rcv, input logic [NUM_PORTS-1:0] v,
                             input int id0, input int id1);
    // Returned IDs leave the model before they reach the DUT
    if (v[0]) begin
      owned[id0] = 1'b0;
    end
    if (v[1]) begin
      owned[id1] = 1'b0;
    end
    @(posedge clk);
    alloc_receivable <= ACW'(rcv);
    dealloc_valid <= v;
    dealloc_entry_id[0] <= ID_W'(id0);
    dealloc_entry_id[1] <= ID_W'(id1);
    @(negedge clk);
  endtask

  task automatic wait_full_offer(input string what);
    int cycles;
    cycles = 0;
    while (int'(alloc_sendable) != NUM_ALLOC && cycles < TIMEOUT) begin
      drive_cycle(0, '0, 0, 0);
      cycles++;
    end
    if (int'(alloc_sendable) != NUM_ALLOC) begin
      report_timeout(what);
    end
  endtask

  // Takes everything on offer until the log holds n IDs
  task automatic take_until(input int n, input string what);
    int cycles;
    cycles = 0;
    while (accepted.size() < n && cycles < TIMEOUT) begin
      drive_cycle(NUM_ALLOC, '0, 0, 0);
      cycles++;
    end
    if (accepted.size() < n) begin
      report_timeout(what);
    end
  endtask

  initial begin : run_test
    int cycles;
    int rcv;
    int pick;
    int id0;
    int id1;
    logic [NUM_PORTS-1:0] v;
    int pool [$];
    bit seen [NUM_ENTRIES];

    seed = 90;
    error_count = 0;
    owned = '0;
    rst = 1'b1;
    alloc_receivable = '0;
    dealloc_valid = '0;
    dealloc_entry_id = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // Start-up offers the two lowest IDs
    wait_full_offer("alloc_sendable did not reach 2 after reset");
    assert (int'(alloc_entry_id[0]) == 0 && int'(alloc_entry_id[1]) == 1) else
      report_mismatch($sformatf("start-up offers %0d and %0d, expected 0 and 1",
                                alloc_entry_id[0], alloc_entry_id[1]));

    // Exhaustion hands out the whole pool in ascending order
    accepted.delete();
    take_until(NUM_ENTRIES, "the pool was not handed out completely");
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      assert (accepted[i] == i) else
        report_mismatch($sformatf("allocation %0d gave ID %0d", i, accepted[i]));
    end
    repeat (20) begin
      drive_cycle(NUM_ALLOC, '0, 0, 0);
      assert (alloc_sendable == '0) else
        report_mismatch($sformatf("empty pool offers %0d IDs", alloc_sendable));
    end

    // ID 5 returned in cycle t must be offered in cycle t+2
    drive_cycle(0, 2'b01, 5, 0);
    drive_cycle(0, '0, 0, 0);
    assert (alloc_sendable == '0) else
      report_mismatch("returned ID offered one cycle after its return");
    drive_cycle(0, '0, 0, 0);
    assert (int'(alloc_sendable) == 1 && int'(alloc_entry_id[0]) == 5) else
      report_mismatch($sformatf("two cycles after return, %0d IDs with slot 0 = %0d",
                                alloc_sendable, alloc_entry_id[0]));
    accepted.delete();
    take_until(1, "returned ID 5 was not taken back");

    // Two returns in one cycle show up as a count of 2 after DELAY cycles
    drive_cycle(0, 2'b11, 2, 6);
    repeat (DELAY) drive_cycle(0, '0, 0, 0);
    assert (int'(dealloc_count) == 2) else
      report_mismatch($sformatf("double return counted as %0d", dealloc_count));

    // Random back-pressure and random returns of held IDs that differ per cycle
    for (int c = 0; c < 2000; c++) begin
      rcv = int'($unsigned($random(seed)) % (NUM_ALLOC + 1));
      v = '0;
      id0 = 0;
      id1 = 0;
      pool.delete();
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        if (owned[e]) begin
          pool.push_back(e);
        end
      end
      if (pool.size() > 0 && ($random(seed) % 2) != 0) begin
        pick = int'($unsigned($random(seed)) % pool.size());
        id0 = pool[pick];
        v[0] = 1'b1;
        pool.delete(pick);
      end
      if (pool.size() > 0 && ($random(seed) % 2) != 0) begin
        pick = int'($unsigned($random(seed)) % pool.size());
        id1 = pool[pick];
        v[1] = 1'b1;
      end
      drive_cycle(rcv, v, id0, id1);
    end

    // Return everything while the allocation port is stalled
    cycles = 0;
    while (owned != '0 && cycles < TIMEOUT) begin
      pool.delete();
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        if (owned[e]) begin
          pool.push_back(e);
        end
      end
      v = 2'b01;
      id0 = pool[0];
      id1 = 0;
      if (pool.size() > 1) begin
        v[1] = 1'b1;
        id1 = pool[1];
      end
      drive_cycle(0, v, id0, id1);
      cycles++;
    end
    if (owned != '0) begin
      report_timeout("held IDs could not all be returned");
    end
    wait_full_offer("alloc_sendable did not settle at 2 after the drain");

    // Taking everything again must give each ID exactly once
    accepted.delete();
    take_until(NUM_ENTRIES, "fewer than 8 IDs came back after the drain");
    foreach (seen[e]) seen[e] = 1'b0;
    foreach (accepted[i]) begin
      assert (!seen[accepted[i]]) else
        report_mismatch($sformatf("ID %0d handed out twice after drain", accepted[i]));
      seen[accepted[i]] = 1'b1;
    end
    assert (accepted.size() == NUM_ENTRIES && owned == '1) else
      report_mismatch($sformatf("drain yielded %0d IDs", accepted.size()));

    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
